//--- source/stall_pkg.sv
// Stall mode and stall count definitions shared by both timers
// Random counts are masked by max_stall, so the LFSR never needs a divider

`default_nettype none

package stall_pkg;

   ////////////////////
   // Stall modes
   ////////////////////

   // Off gives zero stalls, standard uses the port value, random uses the LFSR
   typedef enum logic [1:0] {
      STALL_OFF      = 2'd0,
      STALL_STANDARD = 2'd1,
      STALL_RANDOM   = 2'd2
   } stall_mode_e;

   // Width of every stall count and of max_stall
   localparam int STALL_CNT_W = 8;

   ////////////////////
   // LFSR
   ////////////////////

   localparam int LFSR_W = 16;

   // Galois taps 16, 15, 13 and 4 seen from the right shifting side
   localparam logic [LFSR_W-1:0] LFSR_TAPS = 16'hD008;

   // One Galois step, the output bit folds back into the tap positions
   function automatic logic [LFSR_W-1:0] lfsr_next(input logic [LFSR_W-1:0] state);
      logic [LFSR_W-1:0] shifted;
      shifted = state >> 1;
      return state[0] ? (shifted ^ LFSR_TAPS) : shifted;
   endfunction

endpackage

`default_nettype wire

//--- source/mem_bus_pkg.sv
// Definitions of the req/gnt/rvalid memory bus as seen by the stall unit
// Byte enables cover a 32 bit word only

`default_nettype none

package mem_bus_pkg;

   // One enable bit per byte of the data word
   localparam int BE_W = 4;

   ////////////////////
   // Request path FSM
   ////////////////////

   // Idle waits for a core request
   // Stall holds the request while the grant timer runs
   // Fwd shows the request to memory until it is granted
   typedef enum logic [1:0] {
      REQ_IDLE  = 2'd0,
      REQ_STALL = 2'd1,
      REQ_FWD   = 2'd2
   } req_state_e;

endpackage

`default_nettype wire

//--- source/stall_timer.sv
// Loads a stall count by mode and counts it down; load_i must stay low while busy_o is high
// expired_o marks the last stall cycle, so a zero count expires in its load cycle

`timescale 1ns/1ps
`default_nettype none

module stall_timer
   import stall_pkg::*;
#(
   // Nonzero start value of the private LFSR
   parameter logic [LFSR_W-1:0] SEED = 16'hACE1
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_n_i,
   // Start a new stall
   input  wire logic                   load_i,
   input  wire stall_mode_e            mode_i,
   input  wire logic [STALL_CNT_W-1:0] fixed_cnt_i,
   input  wire logic [STALL_CNT_W-1:0] max_cnt_i,
   // High in the cycle the owner may act at the next edge
   output logic                        expired_o,
   output logic                        busy_o
);

   ////////////////////
   // State
   ////////////////////

   logic [STALL_CNT_W-1:0] cnt_q;
   logic                   active_q;
   logic [LFSR_W-1:0]      lfsr_q;

   // Count picked for the current load
   logic [STALL_CNT_W-1:0] load_cnt;

   ////////////////////
   // Count selection
   ////////////////////

   always_comb begin
      case (mode_i)
         STALL_STANDARD: begin
            load_cnt = fixed_cnt_i;
         end
         // Masking keeps the count at or below max_cnt_i
         STALL_RANDOM: begin
            load_cnt = lfsr_q[STALL_CNT_W-1:0] & max_cnt_i;
         end
         default: begin
            load_cnt = '0;
         end
      endcase
   end

   ////////////////////
   // Down counter
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_q    <= '0;
         active_q <= 1'b0;
         lfsr_q   <= SEED;
      end else if (load_i) begin
         // LFSR steps on every load, whatever the mode
         lfsr_q   <= lfsr_next(lfsr_q);
         cnt_q    <= load_cnt;
         // Zero count never enters the counting phase
         active_q <= (load_cnt != '0);
      end else if (active_q) begin
         cnt_q    <= cnt_q - 1'b1;
         // Last stall cycle ends the counting phase
         active_q <= (cnt_q != STALL_CNT_W'(1));
      end
   end

   // Zero count expires at load, a count of N in the Nth cycle after load
   assign expired_o = load_i ? (load_cnt == '0)
                             : (active_q && (cnt_q == STALL_CNT_W'(1)));

   assign busy_o = active_q;

   ////////////////////
   // Checks
   ////////////////////

   // Owner waits for the running stall before starting another
   a_no_load_while_busy: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      busy_o |-> !load_i
   );

endmodule

`default_nettype wire

//--- source/req_stall_path.sv
// Delays each core request by the grant stall count before it reaches memory
// Core must hold its request steady until grant_core_o; at most RESP_DEPTH stay outstanding

`timescale 1ns/1ps
`default_nettype none

module req_stall_path
   import stall_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int                ADDR_WIDTH = 32,
   parameter int                DATA_WIDTH = 32,
   parameter int                RESP_DEPTH = 4,
   parameter logic [LFSR_W-1:0] SEED       = 16'hACE1
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_n_i,
   // Core request
   input  wire logic                   req_core_i,
   input  wire logic [ADDR_WIDTH-1:0]  addr_core_i,
   input  wire logic                   we_core_i,
   input  wire logic [BE_W-1:0]        be_core_i,
   input  wire logic [DATA_WIDTH-1:0]  wdata_core_i,
   output logic                        grant_core_o,
   // Memory request
   output logic                        req_mem_o,
   output logic [ADDR_WIDTH-1:0]       addr_mem_o,
   output logic                        we_mem_o,
   output logic [BE_W-1:0]             be_mem_o,
   output logic [DATA_WIDTH-1:0]       wdata_mem_o,
   input  wire logic                   grant_mem_i,
   // Pulse per response released to the core
   input  wire logic                   resp_done_i,
   // Configuration
   input  wire stall_mode_e            mode_i,
   input  wire logic [STALL_CNT_W-1:0] gnt_stall_i,
   input  wire logic [STALL_CNT_W-1:0] max_stall_i
);

   localparam int OUT_W = $clog2(RESP_DEPTH + 1);

   req_state_e             state_q;
   req_state_e             state_d;
   logic [OUT_W-1:0]       outstanding_q;
   logic                   room;
   logic                   gnt_load;
   logic                   gnt_expired;

   // Held request, valid from load until grant
   logic [ADDR_WIDTH-1:0]  addr_q;
   logic                   we_q;
   logic [BE_W-1:0]        be_q;
   logic [DATA_WIDTH-1:0]  wdata_q;

   ////////////////////
   // Grant timer
   ////////////////////

   // New request is only taken while the response buffer has room
   assign room     = (outstanding_q < OUT_W'(RESP_DEPTH));
   assign gnt_load = (state_q == REQ_IDLE) && req_core_i && room;

   stall_timer #(
      .SEED (SEED)
   ) stall_timer_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .load_i      (gnt_load),
      .mode_i      (mode_i),
      .fixed_cnt_i (gnt_stall_i),
      .max_cnt_i   (max_stall_i),
      .expired_o   (gnt_expired),
      .busy_o      ()
   );

   ////////////////////
   // FSM
   ////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         REQ_IDLE: begin
            // Zero stall skips the stall state
            if (gnt_load) begin
               state_d = gnt_expired ? REQ_FWD : REQ_STALL;
            end
         end
         REQ_STALL: begin
            if (gnt_expired) begin
               state_d = REQ_FWD;
            end
         end
         REQ_FWD: begin
            // Memory may withhold grant for any number of cycles
            if (grant_mem_i) begin
               state_d = REQ_IDLE;
            end
         end
         default: begin
            state_d = REQ_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= REQ_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Capture the request once, core keeps it stable anyway
   always_ff @(posedge clk_i) begin
      if (gnt_load) begin
         addr_q  <= addr_core_i;
         we_q    <= we_core_i;
         be_q    <= be_core_i;
         wdata_q <= wdata_core_i;
      end
   end

   ////////////////////
   // Outstanding count
   ////////////////////

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         outstanding_q <= '0;
      end else begin
         case ({grant_core_o, resp_done_i})
            2'b10:   outstanding_q <= outstanding_q + 1'b1;
            2'b01:   outstanding_q <= outstanding_q - 1'b1;
            default: outstanding_q <= outstanding_q;
         endcase
      end
   end

   // Core and memory grants fall in the same cycle
   assign grant_core_o = grant_mem_i && (state_q == REQ_FWD);

   assign req_mem_o   = (state_q == REQ_FWD);
   assign addr_mem_o  = addr_q;
   assign we_mem_o    = we_q;
   assign be_mem_o    = be_q;
   assign wdata_mem_o = wdata_q;

   ////////////////////
   // Checks
   ////////////////////

   a_outstanding_bound: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      outstanding_q <= OUT_W'(RESP_DEPTH)
   );

endmodule

`default_nettype wire

//--- source/resp_stall_path.sv
// Buffers memory responses in order and releases each after its own stall count
// Buffer holds RESP_DEPTH words; the request path keeps memory from overrunning it

`timescale 1ns/1ps
`default_nettype none

module resp_stall_path
   import stall_pkg::*;
#(
   parameter int                DATA_WIDTH = 32,
   parameter int                RESP_DEPTH = 4,
   parameter logic [LFSR_W-1:0] SEED       = 16'h5EED
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_n_i,
   // Memory response, one cycle per transaction
   input  wire logic                   rvalid_mem_i,
   input  wire logic [DATA_WIDTH-1:0]  rdata_mem_i,
   // Delayed response to the core
   output logic                        rvalid_core_o,
   output logic [DATA_WIDTH-1:0]       rdata_core_o,
   // Configuration
   input  wire stall_mode_e            mode_i,
   input  wire logic [STALL_CNT_W-1:0] valid_stall_i,
   input  wire logic [STALL_CNT_W-1:0] max_stall_i
);

   localparam int PTR_W = (RESP_DEPTH > 1) ? $clog2(RESP_DEPTH) : 1;
   localparam int CNT_W = $clog2(RESP_DEPTH + 1);

   logic [DATA_WIDTH-1:0] buf_q [RESP_DEPTH];
   logic [PTR_W-1:0]      wr_ptr_q;
   logic [PTR_W-1:0]      rd_ptr_q;
   logic [CNT_W-1:0]      count_q;
   logic                  push;
   logic                  pop;
   logic                  resp_load;
   logic                  resp_expired;
   logic                  resp_busy;

   // Circular pointer step
   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(RESP_DEPTH - 1)) begin
         return '0;
      end
      return ptr + 1'b1;
   endfunction

   ////////////////////
   // Response timer
   ////////////////////

   // Head entry gets its count once the previous one has left
   assign resp_load = (count_q != '0) && !resp_busy;

   stall_timer #(
      .SEED (SEED)
   ) stall_timer_i (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .load_i      (resp_load),
      .mode_i      (mode_i),
      .fixed_cnt_i (valid_stall_i),
      .max_cnt_i   (max_stall_i),
      .expired_o   (resp_expired),
      .busy_o      (resp_busy)
   );

   assign push = rvalid_mem_i;
   assign pop  = resp_expired;

   ////////////////////
   // Buffer
   ////////////////////

   // Data words only, validity lives in count_q
   always_ff @(posedge clk_i) begin
      if (push) begin
         buf_q[wr_ptr_q] <= rdata_mem_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   // Release is the expiry pulse itself, data from the head
   assign rvalid_core_o = pop;
   assign rdata_core_o  = buf_q[rd_ptr_q];

   ////////////////////
   // Checks
   ////////////////////

   a_no_write_when_full: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      (count_q == CNT_W'(RESP_DEPTH)) |-> !rvalid_mem_i
   );

endmodule

`default_nettype wire

//--- source/mem_stall_top.sv
// Stall unit between a core port and a memory port of a req/gnt/rvalid bus
// Configuration levels may change only while no request is pending

`timescale 1ns/1ps
`default_nettype none

module mem_stall_top
   import stall_pkg::*;
   import mem_bus_pkg::*;
#(
   parameter int                ADDR_WIDTH  = 32,
   parameter int                DATA_WIDTH  = 32,
   // Outstanding limit and response buffer depth
   parameter int                RESP_DEPTH  = 4,
   // Distinct seeds keep the two timers out of step
   parameter logic [LFSR_W-1:0] GNT_SEED    = 16'hACE1,
   parameter logic [LFSR_W-1:0] RVALID_SEED = 16'h5EED
) (
   input  wire logic                   clk_i,
   input  wire logic                   rst_n_i,
   // Core port
   input  wire logic                   req_core_i,
   input  wire logic [ADDR_WIDTH-1:0]  addr_core_i,
   input  wire logic                   we_core_i,
   input  wire logic [BE_W-1:0]        be_core_i,
   input  wire logic [DATA_WIDTH-1:0]  wdata_core_i,
   output logic                        grant_core_o,
   output logic                        rvalid_core_o,
   output logic [DATA_WIDTH-1:0]       rdata_core_o,
   // Memory port
   output logic                        req_mem_o,
   output logic [ADDR_WIDTH-1:0]       addr_mem_o,
   output logic                        we_mem_o,
   output logic [BE_W-1:0]             be_mem_o,
   output logic [DATA_WIDTH-1:0]       wdata_mem_o,
   input  wire logic                   grant_mem_i,
   input  wire logic                   rvalid_mem_i,
   input  wire logic [DATA_WIDTH-1:0]  rdata_mem_i,
   // Configuration
   input  wire stall_mode_e            stall_mode_i,
   input  wire logic [STALL_CNT_W-1:0] gnt_stall_i,
   input  wire logic [STALL_CNT_W-1:0] valid_stall_i,
   input  wire logic [STALL_CNT_W-1:0] max_stall_i
);

   ////////////////////
   // Request side
   ////////////////////

   // Each released response frees one outstanding slot
   req_stall_path #(
      .ADDR_WIDTH (ADDR_WIDTH),
      .DATA_WIDTH (DATA_WIDTH),
      .RESP_DEPTH (RESP_DEPTH),
      .SEED       (GNT_SEED)
   ) req_stall_path_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_core_i   (req_core_i),
      .addr_core_i  (addr_core_i),
      .we_core_i    (we_core_i),
      .be_core_i    (be_core_i),
      .wdata_core_i (wdata_core_i),
      .grant_core_o (grant_core_o),
      .req_mem_o    (req_mem_o),
      .addr_mem_o   (addr_mem_o),
      .we_mem_o     (we_mem_o),
      .be_mem_o     (be_mem_o),
      .wdata_mem_o  (wdata_mem_o),
      .grant_mem_i  (grant_mem_i),
      .resp_done_i  (rvalid_core_o),
      .mode_i       (stall_mode_i),
      .gnt_stall_i  (gnt_stall_i),
      .max_stall_i  (max_stall_i)
   );

   ////////////////////
   // Response side
   ////////////////////

   resp_stall_path #(
      .DATA_WIDTH (DATA_WIDTH),
      .RESP_DEPTH (RESP_DEPTH),
      .SEED       (RVALID_SEED)
   ) resp_stall_path_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .rvalid_mem_i  (rvalid_mem_i),
      .rdata_mem_i   (rdata_mem_i),
      .rvalid_core_o (rvalid_core_o),
      .rdata_core_o  (rdata_core_o),
      .mode_i        (stall_mode_i),
      .valid_stall_i (valid_stall_i),
      .max_stall_i   (max_stall_i)
   );

endmodule

`default_nettype wire

//--- test/tb_mem_responder.sv
// Behavioral memory of 64 words, only address bits 7:2 select a word
// Responses come back in order, one per grant; writes get a response too

`timescale 1ns/1ps
`default_nettype none

module tb_mem_responder #(
   parameter logic [31:0] SEED = 32'hee24b497
) (
   input  wire logic        clk_i,
   input  wire logic        rst_n_i,
   // Request from the stall unit
   input  wire logic        req_i,
   input  wire logic [31:0] addr_i,
   input  wire logic        we_i,
   input  wire logic [3:0]  be_i,
   input  wire logic [31:0] wdata_i,
   output logic             gnt_o,
   // Response, a single cycle pulse
   output logic             rvalid_o,
   output logic [31:0]      rdata_o,
   // Random grant and random response delay, per test
   input  wire logic        rand_gnt_i,
   input  wire logic        rand_delay_i
);

   logic [31:0] mem [64];
   // Pending responses, head first, with the cycles still to wait
   logic [31:0] rsp_data_q [$];
   int          rsp_wait_q [$];
   integer      seed;
   logic [31:0] acc_rnd;
   logic [31:0] gnt_rnd;
   logic [5:0]  idx;

   initial begin
      seed     = SEED;
      gnt_o    = 1'b0;
      rvalid_o = 1'b0;
      rdata_o  = '0;
      // Every word differs, so a wrong address shows up as wrong data
      for (int i = 0; i < 64; i++) begin
         mem[i] = {8'hA5, 2'b00, 6'(i), 8'h5A, 2'b00, ~6'(i)};
      end
   end

   ////////////////////
   // Accept
   ////////////////////

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         rsp_data_q.delete();
         rsp_wait_q.delete();
      end else if (req_i && gnt_o) begin
         idx = addr_i[7:2];
         if (we_i) begin
            for (int b = 0; b < 4; b++) begin
               if (be_i[b]) begin
                  mem[idx][8*b +: 8] = wdata_i[8*b +: 8];
               end
            end
         end
         rsp_data_q.push_back(mem[idx]);
         acc_rnd = $random(seed);
         // Up to 7 extra cycles before the response
         rsp_wait_q.push_back(rand_delay_i ? int'(acc_rnd[2:0]) : 0);
      end
   end

   ////////////////////
   // Drive
   ////////////////////

   // Outputs change on the falling edge only
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         gnt_o    <= 1'b0;
         rvalid_o <= 1'b0;
      end else begin
         gnt_rnd = $random(seed);
         // Random grant comes in three cycles out of four
         gnt_o    <= req_i && (!rand_gnt_i || (gnt_rnd[1:0] != 2'b00));
         rvalid_o <= 1'b0;
         if (rsp_wait_q.size() != 0) begin
            if (rsp_wait_q[0] == 0) begin
               rvalid_o <= 1'b1;
               rdata_o  <= rsp_data_q.pop_front();
               void'(rsp_wait_q.pop_front());
            end else begin
               rsp_wait_q[0] = rsp_wait_q[0] - 1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- test/tb_mem_stall_top.sv
// Testbench for the stall unit, core side driven here, memory side by the responder
// Word addresses 0 to 63 only; grant and rvalid gaps are checked with one transaction in flight

`timescale 1ns/1ps
`default_nettype none

module tb_mem_stall_top
   import stall_pkg::*;
   import mem_bus_pkg::*;
();

   localparam int          RESP_DEPTH     = 4;
   localparam logic [31:0] RAND_SEED      = 32'hee24b497;
   localparam int          MAX_CFG_STALL  = 15;
   localparam int          GNT_VALUES [5] = '{0, 1, 2, 5, 12};
   localparam int          VLD_VALUES [4] = '{0, 1, 3, 7};
   // Worst transaction is both stalls, response delay 7 and a grant wait bound of 8
   localparam int          TXN_WORST      = 2 * (MAX_CFG_STALL + 1) + 7 + 8 + 4;
   localparam int          NUM_TXN        = 32 + 5 + 4 + 20 + 40;
   localparam int          TIMEOUT_CYCLES = 2 * (16 + NUM_TXN * TXN_WORST);

   logic                   clk_i;
   logic                   rst_n_i;
   logic                   req_core_i;
   logic [31:0]            addr_core_i;
   logic                   we_core_i;
   logic [BE_W-1:0]        be_core_i;
   logic [31:0]            wdata_core_i;
   logic                   grant_core_o;
   logic                   rvalid_core_o;
   logic [31:0]            rdata_core_o;
   logic                   req_mem_o;
   logic [31:0]            addr_mem_o;
   logic                   we_mem_o;
   logic [BE_W-1:0]        be_mem_o;
   logic [31:0]            wdata_mem_o;
   logic                   grant_mem_i;
   logic                   rvalid_mem_i;
   logic [31:0]            rdata_mem_i;
   stall_mode_e            stall_mode_i;
   logic [STALL_CNT_W-1:0] gnt_stall_i;
   logic [STALL_CNT_W-1:0] valid_stall_i;
   logic [STALL_CNT_W-1:0] max_stall_i;
   logic                   rand_gnt;
   logic                   rand_delay;

   integer      seed;
   int          cyc;
   int          pending;
   int          rsp_cnt;
   int          last_mem_cyc;
   int          last_rsp_gap;
   int          err_cnt;
   int          test_err_base;
   int          tests_run;
   int          tests_failed;
   string       test_name;
   // Reference memory and expected responses in grant order
   logic [31:0] model_mem [64];
   logic [31:0] exp_data_q [$];
   bit          exp_chk_q [$];

   mem_stall_top #(
      .RESP_DEPTH (RESP_DEPTH)
   ) mem_stall_top_i (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .req_core_i    (req_core_i),
      .addr_core_i   (addr_core_i),
      .we_core_i     (we_core_i),
      .be_core_i     (be_core_i),
      .wdata_core_i  (wdata_core_i),
      .grant_core_o  (grant_core_o),
      .rvalid_core_o (rvalid_core_o),
      .rdata_core_o  (rdata_core_o),
      .req_mem_o     (req_mem_o),
      .addr_mem_o    (addr_mem_o),
      .we_mem_o      (we_mem_o),
      .be_mem_o      (be_mem_o),
      .wdata_mem_o   (wdata_mem_o),
      .grant_mem_i   (grant_mem_i),
      .rvalid_mem_i  (rvalid_mem_i),
      .rdata_mem_i   (rdata_mem_i),
      .stall_mode_i  (stall_mode_i),
      .gnt_stall_i   (gnt_stall_i),
      .valid_stall_i (valid_stall_i),
      .max_stall_i   (max_stall_i)
   );

   tb_mem_responder #(
      .SEED (RAND_SEED)
   ) mem_responder_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (req_mem_o),
      .addr_i       (addr_mem_o),
      .we_i         (we_mem_o),
      .be_i         (be_mem_o),
      .wdata_i      (wdata_mem_o),
      .gnt_o        (grant_mem_i),
      .rvalid_o     (rvalid_mem_i),
      .rdata_o      (rdata_mem_i),
      .rand_gnt_i   (rand_gnt),
      .rand_delay_i (rand_delay)
   );

   always #5 clk_i = ~clk_i;

   ////////////////////
   // Helpers
   ////////////////////

   function automatic logic [31:0] fill_word(input logic [5:0] idx);
      return {8'hA5, 2'b00, idx, 8'h5A, 2'b00, ~idx};
   endfunction

   function automatic logic [31:0] rand_word();
      return $random(seed);
   endfunction

   task automatic compare_value(input int expected, input int actual, input string what);
      assert (actual == expected) else begin
         $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
         err_cnt++;
      end
   endtask

   task automatic check_window(input int lo, input int hi, input int actual, input string what);
      assert ((actual >= lo) && (actual <= hi)) else begin
         $display("MISMATCH %s %s: expected %0d to %0d, actual %0d",
                  test_name, what, lo, hi, actual);
         err_cnt++;
      end
   endtask

   task automatic begin_test(input string name);
      test_name     = name;
      test_err_base = err_cnt;
   endtask

   task automatic end_test();
      tests_run++;
      if (err_cnt == test_err_base) begin
         $display("PASS %s", test_name);
      end else begin
         tests_failed++;
         $display("FAIL %s with %0d errors", test_name, err_cnt - test_err_base);
      end
   endtask

   // Config levels change only while nothing is pending
   task automatic configure(input stall_mode_e mode, input int gnt, input int vld, input int max,
                            input logic rgnt, input logic rdel);
      @(negedge clk_i);
      stall_mode_i  = mode;
      gnt_stall_i   = STALL_CNT_W'(gnt);
      valid_stall_i = STALL_CNT_W'(vld);
      max_stall_i   = STALL_CNT_W'(max);
      rand_gnt      = rgnt;
      rand_delay    = rdel;
   endtask

   // Returns at the grant edge; gap counts cycles from request to grant
   task automatic issue(input logic we, input logic [5:0] idx, input logic [31:0] wdata,
                        input logic [BE_W-1:0] be, output int gap);
      int waited;
      waited = 0;
      @(negedge clk_i);
      req_core_i   = 1'b1;
      addr_core_i  = {24'h0, idx, 2'b00};
      we_core_i    = we;
      be_core_i    = be;
      wdata_core_i = wdata;
      do begin
         @(posedge clk_i);
         waited++;
      end while (!grant_core_o);
      gap = waited - 1;
   endtask

   task automatic release_req();
      @(negedge clk_i);
      req_core_i = 1'b0;
   endtask

   task automatic drain();
      while (pending != 0) begin
         @(negedge clk_i);
      end
   endtask

   ////////////////////
   // Monitor and model
   ////////////////////

   always @(posedge clk_i) begin
      logic [31:0] exp_word;
      bit          exp_check;
      logic [5:0]  idx;
      cyc = cyc + 1;
      if (rst_n_i) begin
         if (rvalid_mem_i) begin
            last_mem_cyc = cyc;
         end
         if (rvalid_core_o) begin
            last_rsp_gap = cyc - last_mem_cyc;
            rsp_cnt++;
            pending--;
            assert (exp_data_q.size() != 0) else begin
               $display("Core response in %s without a granted request", test_name);
               err_cnt++;
            end
            if (exp_data_q.size() != 0) begin
               exp_word  = exp_data_q.pop_front();
               exp_check = exp_chk_q.pop_front();
               // Write responses carry no data worth checking
               if (exp_check) begin
                  assert (rdata_core_o == exp_word) else begin
                     $display("MISMATCH %s rdata: expected %h, actual %h",
                              test_name, exp_word, rdata_core_o);
                     err_cnt++;
                  end
               end
            end
         end
         if (grant_core_o) begin
            pending++;
            idx = addr_core_i[7:2];
            if (we_core_i) begin
               for (int b = 0; b < BE_W; b++) begin
                  if (be_core_i[b]) begin
                     model_mem[idx][8*b +: 8] = wdata_core_i[8*b +: 8];
                  end
               end
               exp_data_q.push_back(32'h0);
               exp_chk_q.push_back(1'b0);
            end else begin
               exp_data_q.push_back(model_mem[idx]);
               exp_chk_q.push_back(1'b1);
            end
         end
         assert (pending <= RESP_DEPTH) else begin
            $display("More than %0d responses pending in %s", RESP_DEPTH, test_name);
            err_cnt++;
         end
      end
      if (cyc >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles in %s", cyc, test_name);
         $display("Test failures found");
         $finish;
      end
   end

   ////////////////////
   // Tests
   ////////////////////

   initial begin
      int          gap;
      int          rsp_base;
      logic [31:0] rnd;
      logic [5:0]  addr_list [16];
      seed          = RAND_SEED;
      clk_i         = 1'b0;
      rst_n_i       = 1'b0;
      req_core_i    = 1'b0;
      addr_core_i   = '0;
      we_core_i     = 1'b0;
      be_core_i     = '0;
      wdata_core_i  = '0;
      stall_mode_i  = STALL_OFF;
      gnt_stall_i   = '0;
      valid_stall_i = '0;
      max_stall_i   = '0;
      rand_gnt      = 1'b0;
      rand_delay    = 1'b0;
      cyc           = 0;
      pending       = 0;
      rsp_cnt       = 0;
      last_mem_cyc  = 0;
      last_rsp_gap  = 0;
      err_cnt       = 0;
      tests_run     = 0;
      tests_failed  = 0;
      test_name     = "reset";
      for (int i = 0; i < 64; i++) begin
         model_mem[i] = fill_word(6'(i));
      end
      repeat (16) @(negedge clk_i);
      rst_n_i = 1'b1;

      // Writes back to back, then reads of the same words
      begin_test("off_mode");
      configure(STALL_OFF, 0, 0, 0, 1'b0, 1'b0);
      rsp_base = rsp_cnt;
      for (int i = 0; i < 16; i++) begin
         rnd          = rand_word();
         addr_list[i] = rnd[5:0];
         issue(1'b1, addr_list[i], rand_word(), 4'hF, gap);
      end
      for (int i = 0; i < 16; i++) begin
         issue(1'b0, addr_list[i], '0, 4'hF, gap);
      end
      release_req();
      drain();
      compare_value(32, rsp_cnt - rsp_base, "responses");
      end_test();

      // One read at a time, grant exactly gnt_stall+1 cycles after request
      begin_test("standard_grant");
      for (int i = 0; i < 5; i++) begin
         configure(STALL_STANDARD, GNT_VALUES[i], 2, 0, 1'b0, 1'b0);
         rnd = rand_word();
         issue(1'b0, rnd[5:0], '0, 4'hF, gap);
         release_req();
         drain();
         compare_value(GNT_VALUES[i] + 1, gap, "grant gap");
      end
      end_test();

      begin_test("standard_response");
      for (int i = 0; i < 4; i++) begin
         configure(STALL_STANDARD, 0, VLD_VALUES[i], 0, 1'b0, 1'b0);
         rnd = rand_word();
         issue(1'b0, rnd[5:0], '0, 4'hF, gap);
         release_req();
         drain();
         compare_value(VLD_VALUES[i] + 1, last_rsp_gap, "rvalid gap");
      end
      end_test();

      // Random counts stay within max_stall, single transaction in flight
      begin_test("random_mode");
      configure(STALL_RANDOM, 0, 0, MAX_CFG_STALL, 1'b0, 1'b0);
      for (int i = 0; i < 20; i++) begin
         rnd = rand_word();
         issue(rnd[8], rnd[5:0], rand_word(), rnd[15:12], gap);
         release_req();
         drain();
         check_window(1, MAX_CFG_STALL + 1, gap, "grant gap");
         check_window(1, MAX_CFG_STALL + 1, last_rsp_gap, "rvalid gap");
      end
      end_test();

      // Back to back with memory stalls on both sides
      begin_test("back_pressure");
      configure(STALL_RANDOM, 0, 0, 7, 1'b1, 1'b1);
      rsp_base = rsp_cnt;
      for (int i = 0; i < 40; i++) begin
         rnd = rand_word();
         issue(rnd[8], {2'b00, rnd[3:0]}, rand_word(), rnd[15:12], gap);
      end
      release_req();
      drain();
      compare_value(40, rsp_cnt - rsp_base, "responses");
      compare_value(0, exp_data_q.size(), "unanswered requests");
      end_test();

      $display("Summary %0d tests, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- src.f
source/stall_pkg.sv
source/mem_bus_pkg.sv
source/stall_timer.sv
source/req_stall_path.sv
source/resp_stall_path.sv
source/mem_stall_top.sv
test/tb_mem_responder.sv
test/tb_mem_stall_top.sv

//--- run.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f src.f \
   --top-module tb_mem_stall_top \
   -o sim_mem_stall

out=$(./obj_dir/sim_mem_stall 2>&1) || {
   echo "$out"
   echo "Simulation exited with an error"
   exit 1
}
echo "$out"

if echo "$out" | grep -q '^All tests passed!$'; then
   exit 0
fi
exit 1
